// ==== Makefile ====
# Verilator build and run for the radix-5/3 butterfly testbench

VERILATOR ?= verilator
TOP ?= mrd_rdx53_tb
FLIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= Finished with no errors

SRCS := $(shell cat $(FLIST))
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/mrd_bfp_norm.sv ====
`timescale 1ns/1ps

module mrd_bfp_norm (
	input  logic clk,
	input  logic rst_n,
	input  logic acc_val,
	input  mrd_pkg::accvec_t acc,
	input  mrd_pkg::blk_t acc_blk,
	output logic out_val,
	output mrd_pkg::cvec_t dout,
	output logic [mrd_pkg::w_exp-1:0] exp_out
);

	logic s1_val;
	logic [2:0] s_nxt;
	logic [2:0] s1_s;
	mrd_pkg::accvec_t s1_acc;
	mrd_pkg::blk_t s1_blk;
	logic [mrd_pkg::w_exp+1:0] exp_sum;

	// round half up, then arithmetic shift by 16+s
	function automatic logic signed [mrd_pkg::w_acc:0] rnd(
		input logic signed [mrd_pkg::w_acc-1:0] v, input int s);
		logic signed [mrd_pkg::w_acc:0] vx;
		logic signed [mrd_pkg::w_acc:0] half;
		vx = v;
		half = '0;
		half[15 + s] = 1'b1;
		return (vx + half) >>> (16 + s);
	endfunction

	function automatic logic fits(input logic signed [mrd_pkg::w_acc:0] r);
		return r >= -(2 ** (mrd_pkg::w_data - 1)) && r < 2 ** (mrd_pkg::w_data - 1);
	endfunction

	function automatic logic signed [mrd_pkg::w_data-1:0] sat(
		input logic signed [mrd_pkg::w_acc:0] r);
		if (r >= 2 ** (mrd_pkg::w_data - 1))
			return {1'b0, {(mrd_pkg::w_data - 1){1'b1}}};
		if (r < -(2 ** (mrd_pkg::w_data - 1)))
			return {1'b1, {(mrd_pkg::w_data - 1){1'b0}}};
		return r[mrd_pkg::w_data-1:0];
	endfunction

	// smallest shift where all ten parts fit
	always_comb begin
		logic ok;
		s_nxt = 3'(mrd_pkg::max_shift);
		for (int s = mrd_pkg::max_shift; s >= 0; s--) begin
			ok = 1'b1;
			for (int i = 0; i < mrd_pkg::n_pts; i++) begin
				ok = ok & fits(rnd(acc[i].re, s)) & fits(rnd(acc[i].im, s));
			end
			if (ok)
				s_nxt = 3'(s);
		end
	end

	always_ff @(posedge clk) begin
		s1_s <= s_nxt;
		s1_acc <= acc;
		s1_blk <= acc_blk;
	end

	assign exp_sum = s1_blk.exp + s1_s - s1_blk.margin;

	always_ff @(posedge clk) begin
		for (int i = 0; i < mrd_pkg::n_pts; i++) begin
			dout[i].re <= sat(rnd(s1_acc[i].re, int'(s1_s)));
			dout[i].im <= sat(rnd(s1_acc[i].im, int'(s1_s)));
		end
		exp_out <= exp_sum[mrd_pkg::w_exp-1:0];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_val <= 1'b0;
			out_val <= 1'b0;
		end else begin
			s1_val <= acc_val;
			out_val <= s1_val;
		end
	end

	a_exp_known: assert property (@(posedge clk) disable iff (!rst_n)
		out_val |-> !$isunknown(exp_out));

	// caller exponent range keeps the sum inside w_exp bits
	a_exp_nowrap: assert property (@(posedge clk) disable iff (!rst_n)
		s1_val |-> exp_sum < 2 ** mrd_pkg::w_exp);

endmodule

// ==== hdl/mrd_cmult.sv ====
`timescale 1ns/1ps

module mrd_cmult (
	input  logic clk,
	input  mrd_pkg::cplx_t x,
	input  logic signed [mrd_pkg::w_coef-1:0] c_re,
	input  logic signed [mrd_pkg::w_coef-1:0] c_im,
	output mrd_pkg::acc_t p
);

	logic signed [mrd_pkg::w_data+mrd_pkg::w_coef-1:0] rr;
	logic signed [mrd_pkg::w_data+mrd_pkg::w_coef-1:0] ii;
	logic signed [mrd_pkg::w_data+mrd_pkg::w_coef-1:0] ri;
	logic signed [mrd_pkg::w_data+mrd_pkg::w_coef-1:0] ir;

	// partial products, full precision
	always_comb begin
		rr = x.re * c_re;
		ii = x.im * c_im;
		ri = x.re * c_im;
		ir = x.im * c_re;
	end

	// operands sign extend to the accumulator width before the add
	always_ff @(posedge clk) begin
		p.re <= rr - ii;
		p.im <= ri + ir;
	end

endmodule

// ==== hdl/mrd_pkg.sv ====
package mrd_pkg;

	localparam int w_data = 18;
	// Q1.16 coefficients
	localparam int w_coef = 18;
	localparam int w_acc = 40;
	localparam int n_pts = 5;
	localparam int w_exp = 4;
	localparam int max_shift = 5;

	// pipeline depths
	localparam int lat_core = 3;
	localparam int lat_norm = 2;

	typedef struct packed {
		logic signed [w_data-1:0] re;
		logic signed [w_data-1:0] im;
	} cplx_t;

	typedef cplx_t [n_pts-1:0] cvec_t;

	typedef struct packed {
		logic signed [w_acc-1:0] re;
		logic signed [w_acc-1:0] im;
	} acc_t;

	typedef acc_t [n_pts-1:0] accvec_t;

	// sideband carried with each vector
	typedef struct packed {
		logic factor_is5;
		logic [1:0] margin;
		logic [w_exp-1:0] exp;
	} blk_t;

	// cos and -sin of 2*pi*m/5
	localparam logic signed [w_coef-1:0] cos5_tab [n_pts] = '{
		18'sd65536, 18'sd20252, -18'sd53020, -18'sd53020, 18'sd20252
	};
	localparam logic signed [w_coef-1:0] sin5_tab [n_pts] = '{
		18'sd0, -18'sd62328, -18'sd38521, 18'sd38521, 18'sd62328
	};

	// cos and -sin of 2*pi*m/3
	localparam logic signed [w_coef-1:0] cos3_tab [3] = '{
		18'sd65536, -18'sd32768, -18'sd32768
	};
	localparam logic signed [w_coef-1:0] sin3_tab [3] = '{
		18'sd0, -18'sd56756, 18'sd56756
	};

endpackage

// ==== hdl/mrd_rdx53.sv ====
`timescale 1ns/1ps

module mrd_rdx53 (
	input  logic clk,
	input  logic rst_n,
	input  logic in_val,
	input  mrd_pkg::cvec_t din,
	input  logic [2:0] factor,
	input  logic [1:0] margin_in,
	input  logic [mrd_pkg::w_exp-1:0] exp_in,
	output logic out_val,
	output mrd_pkg::cvec_t dout,
	output logic [mrd_pkg::w_exp-1:0] exp_out
);

	mrd_pkg::blk_t blk;
	logic acc_val;
	mrd_pkg::accvec_t acc;
	mrd_pkg::blk_t acc_blk;

	assign blk.factor_is5 = (factor == 3'd5);
	assign blk.margin = margin_in;
	assign blk.exp = exp_in;

	mrd_rdx53_core i_core (
		.clk    (clk),
		.rst_n  (rst_n),
		.in_val (in_val),
		.din    (din),
		.blk    (blk),
		.acc_val(acc_val),
		.acc    (acc),
		.acc_blk(acc_blk)
	);

	mrd_bfp_norm i_norm (
		.clk    (clk),
		.rst_n  (rst_n),
		.acc_val(acc_val),
		.acc    (acc),
		.acc_blk(acc_blk),
		.out_val(out_val),
		.dout   (dout),
		.exp_out(exp_out)
	);

	a_factor_ok: assert property (@(posedge clk) disable iff (!rst_n)
		in_val |-> factor == 3'd3 || factor == 3'd5);

endmodule

// ==== hdl/mrd_rdx53_core.sv ====
`timescale 1ns/1ps

module mrd_rdx53_core (
	input  logic clk,
	input  logic rst_n,
	input  logic in_val,
	input  mrd_pkg::cvec_t din,
	input  mrd_pkg::blk_t blk,
	output logic acc_val,
	output mrd_pkg::accvec_t acc,
	output mrd_pkg::blk_t acc_blk
);

	logic s1_val;
	logic s2_val;
	mrd_pkg::blk_t s1_blk;
	mrd_pkg::blk_t s2_blk;
	mrd_pkg::cvec_t s1_x;
	mrd_pkg::acc_t prod [mrd_pkg::n_pts][mrd_pkg::n_pts];
	mrd_pkg::accvec_t acc_nxt;

	// sample times 1.0 in Q1.16
	function automatic mrd_pkg::acc_t unit_term(input mrd_pkg::cplx_t x);
		mrd_pkg::acc_t t;
		t.re = {{(mrd_pkg::w_acc - mrd_pkg::w_data - 16){x.re[mrd_pkg::w_data-1]}},
			x.re, 16'b0};
		t.im = {{(mrd_pkg::w_acc - mrd_pkg::w_data - 16){x.im[mrd_pkg::w_data-1]}},
			x.im, 16'b0};
		return t;
	endfunction

	// stage 1, headroom shift
	always_ff @(posedge clk) begin
		for (int n = 0; n < mrd_pkg::n_pts; n++) begin
			s1_x[n].re <= din[n].re <<< blk.margin;
			s1_x[n].im <= din[n].im <<< blk.margin;
		end
		s1_blk <= blk;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_val <= 1'b0;
			s2_val <= 1'b0;
			acc_val <= 1'b0;
		end else begin
			s1_val <= in_val;
			s2_val <= s1_val;
			acc_val <= s2_val;
		end
	end

	// stage 2, one term per input n and output k
	for (genvar n = 0; n < mrd_pkg::n_pts; n++) begin : g_in
		for (genvar k = 0; k < mrd_pkg::n_pts; k++) begin : g_out
			mrd_pkg::acc_t p;

			if (n == 0 || k == 0) begin : g_unit
				always_ff @(posedge clk) begin
					p <= unit_term(s1_x[n]);
				end
			end else begin : g_mult
				localparam int m5 = (n * k) % mrd_pkg::n_pts;
				localparam int m3 = (n * k) % 3;

				mrd_cmult i_cmult (
					.clk (clk),
					.x   (s1_x[n]),
					.c_re(s1_blk.factor_is5 ? mrd_pkg::cos5_tab[m5] : mrd_pkg::cos3_tab[m3]),
					.c_im(s1_blk.factor_is5 ? mrd_pkg::sin5_tab[m5] : mrd_pkg::sin3_tab[m3]),
					.p   (p)
				);
			end

			assign prod[n][k] = p;
		end
	end

	always_ff @(posedge clk) begin
		s2_blk <= s1_blk;
	end

	// exact row sums, radix-3 uses points 0 to 2 only
	always_comb begin
		logic signed [mrd_pkg::w_acc-1:0] sr;
		logic signed [mrd_pkg::w_acc-1:0] si;
		for (int k = 0; k < mrd_pkg::n_pts; k++) begin
			sr = '0;
			si = '0;
			for (int n = 0; n < mrd_pkg::n_pts; n++) begin
				if (s2_blk.factor_is5 || n < 3) begin
					sr = sr + prod[n][k].re;
					si = si + prod[n][k].im;
				end
			end
			if (!s2_blk.factor_is5 && k >= 3) begin
				sr = '0;
				si = '0;
			end
			acc_nxt[k].re = sr;
			acc_nxt[k].im = si;
		end
	end

	// stage 3
	always_ff @(posedge clk) begin
		acc <= acc_nxt;
		acc_blk <= s2_blk;
	end

	// headroom must be a known value for every accepted vector
	a_margin_ok: assert property (@(posedge clk) disable iff (!rst_n)
		in_val |-> !$isunknown(blk.margin));

endmodule

// ==== testbench/mrd_clk_gen.sv ====
`timescale 1ns/1ps

module mrd_clk_gen (
	output logic clk,
	output logic rst_n
);

	localparam int half_period = 20;
	localparam int rst_cycles = 5;

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	// release just after an edge, like any other input
	initial begin
		rst_n = 1'b0;
		repeat (rst_cycles) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

// ==== testbench/mrd_rdx53_tb.sv ====
`timescale 1ns/1ps

module mrd_rdx53_tb;

	localparam int latency = 5;
	localparam int n_rand = 400;
	localparam int n_burst = 12;
	localparam int n_total = n_rand + n_burst + 2;
	localparam int period_ns = 40;

	// shift check attached to a directed vector
	localparam logic [1:0] kind_any = 2'd0;
	localparam logic [1:0] kind_s_zero = 2'd1;
	localparam logic [1:0] kind_s_pos = 2'd2;

	typedef struct packed {
		mrd_pkg::cvec_t dout;
		logic [mrd_pkg::w_exp-1:0] exp_out;
		logic [mrd_pkg::w_exp-1:0] exp_in;
		logic [1:0] margin;
		logic [1:0] kind;
		int due;
	} expect_t;

	logic clk;
	logic rst_n;
	logic in_val;
	mrd_pkg::cvec_t din;
	logic [2:0] factor;
	logic [1:0] margin_in;
	logic [mrd_pkg::w_exp-1:0] exp_in;
	logic [1:0] kind;
	logic out_val;
	mrd_pkg::cvec_t dout;
	logic [mrd_pkg::w_exp-1:0] exp_out;

	int seed = 87;
	int errors = 0;
	int n_in = 0;
	int n_out = 0;
	int cycle = 0;
	int cos5 [5];
	int sin5 [5];
	int cos3 [3];
	int sin3 [3];
	expect_t exp_q [$];

	mrd_clk_gen i_clk_gen (
		.clk  (clk),
		.rst_n(rst_n)
	);

	mrd_rdx53 i_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_val   (in_val),
		.din      (din),
		.factor   (factor),
		.margin_in(margin_in),
		.exp_in   (exp_in),
		.out_val  (out_val),
		.dout     (dout),
		.exp_out  (exp_out)
	);

	function automatic longint round_shift(input longint v, input int sh);
		return (v + (longint'(1) << (15 + sh))) >>> (16 + sh);
	endfunction

	function automatic bit fits_18(input longint v);
		return v >= -131072 && v <= 131071;
	endfunction

	// direct DFT sums, then smallest fitting shift
	function automatic expect_t model(input mrd_pkg::cvec_t x, input logic [2:0] f,
		input logic [1:0] mg, input logic [mrd_pkg::w_exp-1:0] e);
		expect_t r;
		longint sr [5];
		longint si [5];
		longint xr;
		longint xi;
		longint cr;
		longint ci;
		longint rv;
		int np;
		int m;
		int s;
		int scale;
		bit ok;
		r = '0;
		np = (f == 3'd5) ? 5 : 3;
		scale = 1 << mg;
		for (int k = 0; k < 5; k++) begin
			sr[k] = 0;
			si[k] = 0;
		end
		for (int k = 0; k < np; k++) begin
			for (int n = 0; n < np; n++) begin
				m = (n * k) % np;
				xr = longint'($signed(x[n].re)) * scale;
				xi = longint'($signed(x[n].im)) * scale;
				cr = (np == 5) ? cos5[m] : cos3[m];
				ci = (np == 5) ? sin5[m] : sin3[m];
				if (m == 0) begin
					cr = 65536;
					ci = 0;
				end
				sr[k] = sr[k] + xr * cr - xi * ci;
				si[k] = si[k] + xr * ci + xi * cr;
			end
		end
		s = 5;
		for (int t = 5; t >= 0; t--) begin
			ok = 1'b1;
			for (int k = 0; k < 5; k++) begin
				ok = ok && fits_18(round_shift(sr[k], t)) && fits_18(round_shift(si[k], t));
			end
			if (ok)
				s = t;
		end
		for (int k = 0; k < 5; k++) begin
			rv = round_shift(sr[k], s);
			rv = (rv > 131071) ? 131071 : ((rv < -131072) ? -131072 : rv);
			r.dout[k].re = rv[17:0];
			rv = round_shift(si[k], s);
			rv = (rv > 131071) ? 131071 : ((rv < -131072) ? -131072 : rv);
			r.dout[k].im = rv[17:0];
		end
		r.exp_out = 4'(int'(e) + s - int'(mg));
		r.exp_in = e;
		r.margin = mg;
		return r;
	endfunction

	task automatic check_output(input expect_t e);
		int s_dut;
		if (cycle != e.due) begin
			errors++;
			$display("[ERROR] %0t: output in cycle %0d, expected cycle %0d", $time, cycle, e.due);
		end
		for (int k = 0; k < 5; k++) begin
			if (dout[k].re !== e.dout[k].re) begin
				errors++;
				$display("[ERROR] %0t: dout[%0d].re = %0d, expected %0d",
					$time, k, dout[k].re, e.dout[k].re);
			end
			if (dout[k].im !== e.dout[k].im) begin
				errors++;
				$display("[ERROR] %0t: dout[%0d].im = %0d, expected %0d",
					$time, k, dout[k].im, e.dout[k].im);
			end
		end
		if (exp_out !== e.exp_out) begin
			errors++;
			$display("[ERROR] %0t: exp_out = %0d, expected %0d", $time, exp_out, e.exp_out);
		end
		s_dut = int'(exp_out) + int'(e.margin) - int'(e.exp_in);
		if (e.kind == kind_s_zero && s_dut != 0) begin
			errors++;
			$display("[ERROR] %0t: impulse gave shift %0d, expected 0", $time, s_dut);
		end
		if (e.kind == kind_s_pos && s_dut <= 0) begin
			errors++;
			$display("[ERROR] %0t: full-scale vector gave shift %0d, expected > 0", $time, s_dut);
		end
	endtask

	function automatic int rand_part(input int lim);
		return int'({$random(seed)} % (2 * lim - 1)) - (lim - 1);
	endfunction

	// parts stay below 2^(17-margin) so nothing saturates
	task automatic drive_random(input bit valid);
		int lim;
		int v;
		in_val = valid;
		kind = kind_any;
		factor = ({$random(seed)} % 2 == 0) ? 3'd5 : 3'd3;
		margin_in = 2'({$random(seed)} % 4);
		exp_in = 4'(3 + {$random(seed)} % 8);
		lim = 1 << (17 - int'(margin_in));
		for (int n = 0; n < 5; n++) begin
			v = rand_part(lim);
			din[n].re = v[17:0];
			v = rand_part(lim);
			din[n].im = v[17:0];
		end
	endtask

	// compare on the falling edge, where outputs are settled
	always @(negedge clk) begin : monitor
		expect_t e;
		if (rst_n) begin
			cycle++;
			if (out_val === 1'b1) begin
				n_out++;
				if (exp_q.size() == 0) begin
					errors++;
					$display("[ERROR] %0t: out_val high with no vector in flight", $time);
				end else begin
					e = exp_q.pop_front();
					check_output(e);
				end
			end else if (out_val !== 1'b0) begin
				errors++;
				$display("[ERROR] %0t: out_val is unknown", $time);
			end else if (exp_q.size() != 0 && exp_q[0].due <= cycle) begin
				errors++;
				$display("[ERROR] %0t: no output for vector due in cycle %0d", $time, exp_q[0].due);
				void'(exp_q.pop_front());
			end
			if (in_val) begin
				n_in++;
				e = model(din, factor, margin_in, exp_in);
				e.kind = kind;
				e.due = cycle + latency;
				exp_q.push_back(e);
			end
		end
	end

	initial begin : stimulus
		int sent;
		in_val = 1'b0;
		din = '0;
		factor = 3'd5;
		margin_in = 2'd0;
		exp_in = 4'd3;
		kind = kind_any;
		for (int m = 0; m < 5; m++) begin
			cos5[m] = mrd_pkg::cos5_tab[m];
			sin5[m] = mrd_pkg::sin5_tab[m];
		end
		for (int m = 0; m < 3; m++) begin
			cos3[m] = mrd_pkg::cos3_tab[m];
			sin3[m] = mrd_pkg::sin3_tab[m];
		end
		@(posedge rst_n);
		repeat (3) @(posedge clk);

		// impulse at point 0
		@(posedge clk);
		#1;
		din = '0;
		din[0].re = 18'sd40000;
		din[0].im = -18'sd25000;
		factor = 3'd5;
		margin_in = 2'd0;
		exp_in = 4'd6;
		kind = kind_s_zero;
		in_val = 1'b1;

		// full-scale constant, radix-5
		@(posedge clk);
		#1;
		for (int n = 0; n < 5; n++) begin
			din[n].re = 18'sd131071;
			din[n].im = 18'sd0;
		end
		exp_in = 4'd4;
		kind = kind_s_pos;
		@(posedge clk);
		#1;
		in_val = 1'b0;
		kind = kind_any;

		for (int i = 0; i < n_burst; i++) begin
			@(posedge clk);
			#1;
			drive_random(1'b1);
		end
		sent = 0;
		while (sent < n_rand) begin
			@(posedge clk);
			#1;
			if ({$random(seed)} % 100 < 60) begin
				drive_random(1'b1);
				sent++;
			end else begin
				drive_random(1'b0);
			end
		end
		@(posedge clk);
		#1;
		in_val = 1'b0;

		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (2 * latency) @(negedge clk);
		if (n_in != n_out) begin
			errors++;
			$display("vector count mismatch: %0d went in, %0d came out", n_in, n_out);
		end
		$display("errors: %0d  vectors in: %0d  vectors out: %0d", errors, n_in, n_out);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial begin : watchdog
		#((n_total * 4 + 200) * period_ns);
		$display("timeout: run still busy after %0d cycles", n_total * 4 + 200);
		$display("errors: %0d  vectors in: %0d  vectors out: %0d", errors, n_in, n_out);
		$display("Finished with errors");
		$finish;
	end

endmodule

// ==== vlog.f ====
hdl/mrd_pkg.sv
hdl/mrd_cmult.sv
hdl/mrd_rdx53_core.sv
hdl/mrd_bfp_norm.sv
hdl/mrd_rdx53.sv
testbench/mrd_clk_gen.sv
testbench/mrd_rdx53_tb.sv
